/* synth_i2c_pkg.sv */
// Shared types and register map for the voice I2C slave covering addresses 0x00 to 0x12 only
package synth_i2c_pkg;

    typedef logic [6:0] dev_addr_t;  // 7 bit device address only
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // ========================================
    // Protocol states
    // ========================================
    typedef enum logic [3:0] {
        st_idle,
        st_addr,
        st_addr_ack,
        st_reg_addr,
        st_reg_ack,
        st_write_data,
        st_write_ack,
        st_read_data,
        st_read_ack
    } i2c_state_e;

    // One byte write from the engine to the bank
    typedef struct packed {
        logic      strobe;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    // ========================================
    // Register groups
    // ========================================
    typedef struct packed {
        reg_data_t control;
        reg_data_t waveform;
        reg_data_t freq_low;   // 24 bit frequency, little endian
        reg_data_t freq_mid;
        reg_data_t freq_high;
        reg_data_t duty;
        reg_data_t phase_offset;
    } osc_regs_t;

    typedef struct packed {
        reg_data_t attack;
        reg_data_t decay;
        reg_data_t sustain;
        reg_data_t release_rate;
        reg_data_t amplitude;
    } env_regs_t;

    typedef struct packed {
        reg_data_t svf1_cutoff;
        reg_data_t svf1_resonance;
        reg_data_t svf2_cutoff;
        reg_data_t svf2_resonance;
        reg_data_t filter_mode;
        reg_data_t filter_enable;
    } filter_regs_t;

    // Status byte bits 4, 3:1 and 0
    typedef struct packed {
        logic       osc_running;
        logic [2:0] adsr_state;
        logic       gate_active;
    } voice_status_t;

    // ========================================
    // Register addresses
    // ========================================
    localparam reg_addr_t reg_control_addr        = 8'h00;
    localparam reg_addr_t reg_waveform_addr       = 8'h01;
    localparam reg_addr_t reg_freq_low_addr       = 8'h02;
    localparam reg_addr_t reg_freq_mid_addr       = 8'h03;
    localparam reg_addr_t reg_freq_high_addr      = 8'h04;
    localparam reg_addr_t reg_duty_addr           = 8'h05;
    localparam reg_addr_t reg_phase_offset_addr   = 8'h06;
    localparam reg_addr_t reg_attack_addr         = 8'h07;
    localparam reg_addr_t reg_decay_addr          = 8'h08;
    localparam reg_addr_t reg_sustain_addr        = 8'h09;
    localparam reg_addr_t reg_release_addr        = 8'h0A;
    localparam reg_addr_t reg_amplitude_addr      = 8'h0B;
    localparam reg_addr_t reg_svf1_cutoff_addr    = 8'h0C;
    localparam reg_addr_t reg_svf1_resonance_addr = 8'h0D;
    localparam reg_addr_t reg_svf2_cutoff_addr    = 8'h0E;
    localparam reg_addr_t reg_svf2_resonance_addr = 8'h0F;
    localparam reg_addr_t reg_filter_mode_addr    = 8'h10;
    localparam reg_addr_t reg_filter_enable_addr  = 8'h11;
    localparam reg_addr_t reg_status_addr         = 8'h12;  // Read only
    localparam reg_addr_t reg_last_addr           = 8'h12;
    localparam reg_data_t unmapped_value          = 8'hFF;

    // Reset values
    localparam osc_regs_t osc_default = '{duty: 8'h80, default: 8'h00};  // 50% duty
    localparam env_regs_t env_default = '{attack: 8'h10, decay: 8'h20, sustain: 8'hC0,
                                          release_rate: 8'h30, amplitude: 8'hFF};
    localparam filter_regs_t filter_default = '{svf1_cutoff: 8'hFF, svf2_cutoff: 8'hFF,
                                                filter_enable: 8'h01, default: 8'h00};

endpackage

/* i2c_line_sync.sv */
// SCL and SDA must hold each level for several clk periods since edges are seen 2 to 3 clk late
`timescale 1ns/1ps

module i2c_line_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic scl_in,
    input  logic sda_in,
    output logic scl,
    output logic sda,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det
);

    logic [2:0] scl_q;  // Bit 2 is the oldest stage
    logic [2:0] sda_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= 3'b111;  // Idle bus is high
            sda_q <= 3'b111;
        end else begin
            scl_q <= {scl_q[1:0], scl_in};
            sda_q <= {sda_q[1:0], sda_in};
        end
    end

    assign scl      = scl_q[2];
    assign sda      = sda_q[2];
    assign scl_rise = (scl_q[2:1] == 2'b01);
    assign scl_fall = (scl_q[2:1] == 2'b10);

    // SDA moving while SCL is high marks START or STOP
    assign start_det = scl_q[2] && (sda_q[2:1] == 2'b10);
    assign stop_det  = scl_q[2] && (sda_q[2:1] == 2'b01);

    a_start_stop_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_det && stop_det));

endmodule

/* i2c_slave_engine.sv */
// Bit level slave with 7 bit addressing and no clock stretching or general call
`timescale 1ns/1ps

module i2c_slave_engine #(
    parameter synth_i2c_pkg::dev_addr_t dev_addr = 7'h50
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     scl,
    input  logic                     sda,
    input  logic                     scl_rise,
    input  logic                     scl_fall,
    input  logic                     start_det,
    input  logic                     stop_det,
    input  synth_i2c_pkg::reg_data_t rd_data,
    output synth_i2c_pkg::reg_wr_t   wr,
    output synth_i2c_pkg::reg_addr_t rd_addr,
    output logic                     sda_out,
    output logic                     sda_oe
);

    synth_i2c_pkg::i2c_state_e state;
    logic [2:0]                bit_cnt;  // Wraps to 0 after the eighth bit
    synth_i2c_pkg::reg_data_t  shift_q;
    synth_i2c_pkg::reg_addr_t  reg_ptr;  // Survives STOP
    logic                      rw_bit;   // High for a read transfer

    // In the read ACK slot the next byte comes from the following address
    assign rd_addr = (state == synth_i2c_pkg::st_read_ack) ? reg_ptr + 8'd1 : reg_ptr;

    // ========================================
    // Protocol FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= synth_i2c_pkg::st_idle;
            bit_cnt <= '0;
            shift_q <= '0;
            reg_ptr <= '0;
            rw_bit  <= 1'b0;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
            wr      <= '0;
        end else begin
            wr.strobe <= 1'b0;
            if (start_det) begin  // Also covers repeated START
                state   <= synth_i2c_pkg::st_addr;
                bit_cnt <= '0;
                shift_q <= '0;
                sda_oe  <= 1'b0;
            end else if (stop_det) begin
                state   <= synth_i2c_pkg::st_idle;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end else if (scl_rise) begin
                case (state)
                    synth_i2c_pkg::st_addr: begin
                        shift_q <= {shift_q[6:0], sda};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            if (shift_q[6:0] == dev_addr) begin
                                rw_bit <= sda;  // Eighth bit is R/W
                                state  <= synth_i2c_pkg::st_addr_ack;
                            end else begin
                                state <= synth_i2c_pkg::st_idle;  // Not us
                            end
                        end
                    end
                    synth_i2c_pkg::st_addr_ack: begin
                        bit_cnt <= '0;
                        if (rw_bit) begin
                            shift_q <= rd_data;  // First read byte at the pointer
                            state   <= synth_i2c_pkg::st_read_data;
                        end else begin
                            state <= synth_i2c_pkg::st_reg_addr;
                        end
                    end
                    synth_i2c_pkg::st_reg_addr: begin
                        shift_q <= {shift_q[6:0], sda};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            reg_ptr <= {shift_q[6:0], sda};
                            state   <= synth_i2c_pkg::st_reg_ack;
                        end
                    end
                    synth_i2c_pkg::st_reg_ack, synth_i2c_pkg::st_write_ack: begin
                        state <= synth_i2c_pkg::st_write_data;
                    end
                    synth_i2c_pkg::st_write_data: begin
                        shift_q <= {shift_q[6:0], sda};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            wr.strobe <= 1'b1;
                            wr.addr   <= reg_ptr;
                            wr.data   <= {shift_q[6:0], sda};
                            reg_ptr   <= reg_ptr + 8'd1;  // Auto increment
                            state     <= synth_i2c_pkg::st_write_ack;
                        end
                    end
                    synth_i2c_pkg::st_read_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= synth_i2c_pkg::st_read_ack;
                        end
                    end
                    synth_i2c_pkg::st_read_ack: begin
                        if (!sda) begin  // Master ACK so keep reading
                            reg_ptr <= rd_addr;
                            shift_q <= rd_data;
                            state   <= synth_i2c_pkg::st_read_data;
                        end else begin
                            state <= synth_i2c_pkg::st_idle;
                        end
                    end
                    default: state <= synth_i2c_pkg::st_idle;  // Idle waits for START
                endcase
            end else if (scl_fall) begin
                case (state)
                    synth_i2c_pkg::st_addr_ack,
                    synth_i2c_pkg::st_reg_ack,
                    synth_i2c_pkg::st_write_ack: begin
                        sda_out <= 1'b0;  // ACK
                        sda_oe  <= 1'b1;
                    end
                    synth_i2c_pkg::st_read_data: begin
                        sda_out <= shift_q[7];  // MSB first
                        sda_oe  <= ~shift_q[7];  // Ones are left to the pull-up
                        shift_q <= {shift_q[6:0], 1'b1};
                    end
                    default: begin
                        sda_out <= 1'b1;
                        sda_oe  <= 1'b0;
                    end
                endcase
            end
        end
    end

    // ========================================
    // Assertions
    // ========================================
    a_idle_released: assert property (@(posedge clk) disable iff (!rst_n)
        state == synth_i2c_pkg::st_idle |-> !sda_oe);

    a_strobe_from_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr.strobe |-> $past(state) == synth_i2c_pkg::st_write_data);

    // The slave only moves SDA while SCL is low, except when a bus condition releases it
    a_sda_scl_low: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sda_oe) |-> !scl || $past(start_det || stop_det));

endmodule

/* synth_reg_bank.sv */
// Voice registers 0x00 to 0x11 are writable, 0x12 is live status and higher addresses read 0xFF
`timescale 1ns/1ps

module synth_reg_bank (
    input  logic                         clk,
    input  logic                         rst_n,
    input  synth_i2c_pkg::reg_wr_t       wr,
    input  synth_i2c_pkg::reg_addr_t     rd_addr,
    input  synth_i2c_pkg::voice_status_t status,
    output synth_i2c_pkg::reg_data_t     rd_data,
    output synth_i2c_pkg::osc_regs_t     osc,
    output synth_i2c_pkg::env_regs_t     env,
    output synth_i2c_pkg::filter_regs_t  filter
);

    // ========================================
    // Write decode
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            osc    <= synth_i2c_pkg::osc_default;
            env    <= synth_i2c_pkg::env_default;
            filter <= synth_i2c_pkg::filter_default;
        end else if (wr.strobe && (wr.addr < synth_i2c_pkg::reg_last_addr)) begin
            // Status and everything above it take no writes
            case (wr.addr)
                synth_i2c_pkg::reg_control_addr:        osc.control         <= wr.data;
                synth_i2c_pkg::reg_waveform_addr:       osc.waveform        <= wr.data;
                synth_i2c_pkg::reg_freq_low_addr:       osc.freq_low        <= wr.data;
                synth_i2c_pkg::reg_freq_mid_addr:       osc.freq_mid        <= wr.data;
                synth_i2c_pkg::reg_freq_high_addr:      osc.freq_high       <= wr.data;
                synth_i2c_pkg::reg_duty_addr:           osc.duty            <= wr.data;
                synth_i2c_pkg::reg_phase_offset_addr:   osc.phase_offset    <= wr.data;
                synth_i2c_pkg::reg_attack_addr:         env.attack          <= wr.data;
                synth_i2c_pkg::reg_decay_addr:          env.decay           <= wr.data;
                synth_i2c_pkg::reg_sustain_addr:        env.sustain         <= wr.data;
                synth_i2c_pkg::reg_release_addr:        env.release_rate    <= wr.data;
                synth_i2c_pkg::reg_amplitude_addr:      env.amplitude       <= wr.data;
                synth_i2c_pkg::reg_svf1_cutoff_addr:    filter.svf1_cutoff    <= wr.data;
                synth_i2c_pkg::reg_svf1_resonance_addr: filter.svf1_resonance <= wr.data;
                synth_i2c_pkg::reg_svf2_cutoff_addr:    filter.svf2_cutoff    <= wr.data;
                synth_i2c_pkg::reg_svf2_resonance_addr: filter.svf2_resonance <= wr.data;
                synth_i2c_pkg::reg_filter_mode_addr:    filter.filter_mode    <= wr.data;
                synth_i2c_pkg::reg_filter_enable_addr:  filter.filter_enable  <= wr.data;
                default: ;
            endcase
        end
    end

    // ========================================
    // Read mux
    // ========================================
    always_comb begin
        rd_data = synth_i2c_pkg::unmapped_value;  // Past the status byte
        case (rd_addr)
            synth_i2c_pkg::reg_control_addr:        rd_data = osc.control;
            synth_i2c_pkg::reg_waveform_addr:       rd_data = osc.waveform;
            synth_i2c_pkg::reg_freq_low_addr:       rd_data = osc.freq_low;
            synth_i2c_pkg::reg_freq_mid_addr:       rd_data = osc.freq_mid;
            synth_i2c_pkg::reg_freq_high_addr:      rd_data = osc.freq_high;
            synth_i2c_pkg::reg_duty_addr:           rd_data = osc.duty;
            synth_i2c_pkg::reg_phase_offset_addr:   rd_data = osc.phase_offset;
            synth_i2c_pkg::reg_attack_addr:         rd_data = env.attack;
            synth_i2c_pkg::reg_decay_addr:          rd_data = env.decay;
            synth_i2c_pkg::reg_sustain_addr:        rd_data = env.sustain;
            synth_i2c_pkg::reg_release_addr:        rd_data = env.release_rate;
            synth_i2c_pkg::reg_amplitude_addr:      rd_data = env.amplitude;
            synth_i2c_pkg::reg_svf1_cutoff_addr:    rd_data = filter.svf1_cutoff;
            synth_i2c_pkg::reg_svf1_resonance_addr: rd_data = filter.svf1_resonance;
            synth_i2c_pkg::reg_svf2_cutoff_addr:    rd_data = filter.svf2_cutoff;
            synth_i2c_pkg::reg_svf2_resonance_addr: rd_data = filter.svf2_resonance;
            synth_i2c_pkg::reg_filter_mode_addr:    rd_data = filter.filter_mode;
            synth_i2c_pkg::reg_filter_enable_addr:  rd_data = filter.filter_enable;
            synth_i2c_pkg::reg_status_addr:         rd_data = {3'b000, status};  // Live
            default: ;
        endcase
    end

    // Voice outputs only move on the edge that follows a write strobe
    a_hold_without_write: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(wr.strobe) |-> $stable({osc, env, filter}));

endmodule

/* synth_i2c_top.sv */
// Voice I2C slave whose device address is fixed at elaboration by dev_addr and SDA is open drain
`timescale 1ns/1ps

module synth_i2c_top #(
    parameter synth_i2c_pkg::dev_addr_t dev_addr = 7'h50
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scl_in,
    input  logic                         sda_in,
    input  synth_i2c_pkg::voice_status_t status,
    output logic                         sda_out,
    output logic                         sda_oe,   // High drives the pad
    output synth_i2c_pkg::osc_regs_t     osc,
    output synth_i2c_pkg::env_regs_t     env,
    output synth_i2c_pkg::filter_regs_t  filter
);

    logic                     scl;
    logic                     sda;
    logic                     scl_rise;
    logic                     scl_fall;
    logic                     start_det;
    logic                     stop_det;
    synth_i2c_pkg::reg_wr_t   wr;
    synth_i2c_pkg::reg_addr_t rd_addr;
    synth_i2c_pkg::reg_data_t rd_data;

    i2c_line_sync u_line_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda       (sda),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    i2c_slave_engine #(
        .dev_addr (dev_addr)
    ) u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl       (scl),
        .sda       (sda),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det),
        .rd_data   (rd_data),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

    synth_reg_bank u_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd_addr (rd_addr),
        .status  (status),
        .rd_data (rd_data),
        .osc     (osc),
        .env     (env),
        .filter  (filter)
    );

endmodule

/* tb_synth_i2c.sv */
// Open-drain master at 8 clk per SCL half period, checked against a register model at 7'h50
`timescale 1ns/1ps

module tb_synth_i2c;

    localparam synth_i2c_pkg::dev_addr_t dev_id = 7'h50;

    logic                         clk;
    logic                         rst_n;
    logic                         scl_in;
    logic                         sda_in;
    logic                         sda_drv;  // Master side of the line
    synth_i2c_pkg::voice_status_t status;
    logic                         sda_out;
    logic                         sda_oe;
    synth_i2c_pkg::osc_regs_t     osc;
    synth_i2c_pkg::env_regs_t     env;
    synth_i2c_pkg::filter_regs_t  filter;

    synth_i2c_pkg::reg_data_t mem_m [0:255];  // Register map model
    logic [31:0]              lfsr_q;
    string                    cur_test;
    int                       err_count;
    int                       err_start;
    int                       tests_ok;
    int                       tests_bad;

    synth_i2c_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .scl_in  (scl_in),
        .sda_in  (sda_in),
        .status  (status),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .osc     (osc),
        .env     (env),
        .filter  (filter)
    );

    always #50 clk = ~clk;

    // Wired AND with the slave, which only counts where it drives the pad
    always @(posedge clk) sda_in <= sda_drv & (sda_oe ? sda_out : 1'b1);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ========================================
    // Reference model
    // ========================================
    task automatic model_reset();
        logic [55:0]              o;
        logic [39:0]              e;
        logic [47:0]              f;
        synth_i2c_pkg::reg_addr_t a;
        o = synth_i2c_pkg::osc_default;
        e = synth_i2c_pkg::env_default;
        f = synth_i2c_pkg::filter_default;
        a = 8'h00;
        repeat (7) begin
            mem_m[a] = o[55:48];
            o = o << 8;
            a = a + 8'd1;
        end
        repeat (5) begin
            mem_m[a] = e[39:32];
            e = e << 8;
            a = a + 8'd1;
        end
        repeat (6) begin
            mem_m[a] = f[47:40];
            f = f << 8;
            a = a + 8'd1;
        end
    endtask

    task automatic model_write(input synth_i2c_pkg::reg_addr_t a,
                               input synth_i2c_pkg::reg_data_t d);
        if (a < synth_i2c_pkg::reg_status_addr) begin
            mem_m[a] = d;  // Status and above are read only
        end
    endtask

    function automatic synth_i2c_pkg::reg_data_t model_read(input synth_i2c_pkg::reg_addr_t a);
        if (a < synth_i2c_pkg::reg_status_addr) begin
            return mem_m[a];
        end else if (a == synth_i2c_pkg::reg_status_addr) begin
            return {3'b000, status.osc_running, status.adsr_state, status.gate_active};
        end
        return 8'hFF;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_byte(input string what, input synth_i2c_pkg::reg_data_t exp,
                              input synth_i2c_pkg::reg_data_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_osc(input synth_i2c_pkg::osc_regs_t exp,
                             input synth_i2c_pkg::osc_regs_t act);
        if (act !== exp) begin
            $display("Fail %s osc: expected %h, actual %h", cur_test, exp, act);
            err_count++;
        end
    endtask

    task automatic check_env(input synth_i2c_pkg::env_regs_t exp,
                             input synth_i2c_pkg::env_regs_t act);
        if (act !== exp) begin
            $display("Fail %s env: expected %h, actual %h", cur_test, exp, act);
            err_count++;
        end
    endtask

    task automatic check_filter(input synth_i2c_pkg::filter_regs_t exp,
                                input synth_i2c_pkg::filter_regs_t act);
        if (act !== exp) begin
            $display("Fail %s filter: expected %h, actual %h", cur_test, exp, act);
            err_count++;
        end
    endtask

    task automatic check_ack(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s %s ack bit: expected %b, actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_outputs();
        check_osc({mem_m[0], mem_m[1], mem_m[2], mem_m[3], mem_m[4], mem_m[5], mem_m[6]}, osc);
        check_env({mem_m[7], mem_m[8], mem_m[9], mem_m[10], mem_m[11]}, env);
        check_filter({mem_m[12], mem_m[13], mem_m[14], mem_m[15], mem_m[16], mem_m[17]}, filter);
    endtask

    // ========================================
    // Bit-banged master
    // ========================================
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (sda_oe && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (sda_oe) begin
            $display("Slave still pulls SDA low after 200 clk of waiting in %s", cur_test);
            err_count++;
        end
    endtask

    task automatic clock_bit(input logic drive, output logic sampled);
        @(posedge clk);
        scl_in <= 1'b0;
        wait_clks(2);
        sda_drv <= drive;  // Well inside the low phase
        wait_clks(6);
        scl_in <= 1'b1;
        wait_clks(4);
        sampled = sda_in;  // Middle of the high phase
        wait_clks(4);
    endtask

    task automatic start_cond();
        wait_bus_idle();
        @(posedge clk);
        scl_in  <= 1'b1;
        sda_drv <= 1'b1;
        wait_clks(8);
        sda_drv <= 1'b0;  // Falls while SCL is high
        wait_clks(8);
    endtask

    task automatic stop_cond();
        @(posedge clk);
        scl_in <= 1'b0;
        wait_clks(2);
        sda_drv <= 1'b0;
        wait_clks(6);
        scl_in <= 1'b1;
        wait_clks(8);
        sda_drv <= 1'b1;  // Rises while SCL is high
        wait_clks(8);
    endtask

    task automatic send_byte(input synth_i2c_pkg::reg_data_t b, output logic ack);
        logic unused_bit;
        repeat (8) begin
            clock_bit(b[7], unused_bit);
            b = b << 1;
        end
        clock_bit(1'b1, ack);  // Line released for the slave
    endtask

    task automatic recv_byte(input logic nack, output synth_i2c_pkg::reg_data_t d);
        logic b;
        d = '0;
        repeat (8) begin
            clock_bit(1'b1, b);
            d = {d[6:0], b};
        end
        clock_bit(nack, b);
    endtask

    // Random data, also used with n = 0 to only set the pointer
    task automatic write_burst(input synth_i2c_pkg::reg_addr_t first, input int n);
        synth_i2c_pkg::reg_addr_t a;
        synth_i2c_pkg::reg_data_t d;
        logic                     ack;
        start_cond();
        send_byte({dev_id, 1'b0}, ack);
        check_ack("device address", 1'b0, ack);
        send_byte(first, ack);
        check_ack("register address", 1'b0, ack);
        a = first;
        for (int i = 0; i < n; i++) begin
            d = 8'(rand_bits(8));
            send_byte(d, ack);
            check_ack($sformatf("write to %h", a), 1'b0, ack);
            model_write(a, d);
            a = a + 8'd1;
        end
        stop_cond();
    endtask

    task automatic read_burst(input synth_i2c_pkg::reg_addr_t first, input int n);
        synth_i2c_pkg::reg_addr_t a;
        synth_i2c_pkg::reg_data_t d;
        logic                     ack;
        write_burst(first, 0);
        start_cond();
        send_byte({dev_id, 1'b1}, ack);
        check_ack("device address", 1'b0, ack);
        a = first;
        for (int i = 0; i < n; i++) begin
            recv_byte(i == n - 1, d);  // NACK on the last byte
            check_byte($sformatf("read of %h", a), model_read(a), d);
            a = a + 8'd1;
        end
        stop_cond();
    endtask

    task automatic test_begin(input string name);
        cur_test  = name;
        err_start = err_count;
    endtask

    task automatic test_end();
        if (err_count == err_start) begin
            tests_ok++;
            $display("%s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", cur_test, err_count - err_start);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        synth_i2c_pkg::reg_addr_t  first;
        int                        len;
        synth_i2c_pkg::dev_addr_t  bad;
        logic                      ack;
        clk       = 1'b0;
        rst_n     = 1'b0;
        scl_in    = 1'b1;
        sda_in    = 1'b1;
        sda_drv   = 1'b1;
        status    = '0;
        lfsr_q    = 32'h9cfc;
        err_count = 0;
        tests_ok  = 0;
        tests_bad = 0;
        model_reset();
        wait_clks(5);
        rst_n <= 1'b1;
        status <= 5'(rand_bits(5));
        wait_clks(4);

        test_begin("reset defaults");
        check_outputs();
        read_burst(8'h00, 19);
        test_end();

        test_begin("write bursts");
        repeat (4) begin
            first = 8'(rand_bits(8) % 18);
            len = 1 + rand_bits(3);
            write_burst(first, len);
            check_outputs();
            read_burst(first, len);
        end
        test_end();

        test_begin("status register");
        @(posedge clk);
        status <= 5'(rand_bits(5));
        read_burst(synth_i2c_pkg::reg_status_addr, 1);
        write_burst(synth_i2c_pkg::reg_status_addr, 1);  // ACKed, then dropped
        check_outputs();
        read_burst(synth_i2c_pkg::reg_status_addr, 1);
        test_end();

        test_begin("wrong device address");
        bad = 7'(rand_bits(7));
        if (bad == dev_id) begin
            bad = bad ^ 7'h01;
        end
        start_cond();
        send_byte({bad, 1'b0}, ack);
        check_ack("device address", 1'b1, ack);
        send_byte(8'h00, ack);
        check_ack("register address", 1'b1, ack);
        send_byte(8'(rand_bits(8)), ack);
        check_ack("data", 1'b1, ack);
        stop_cond();
        check_outputs();
        test_end();

        test_begin("unmapped addresses");
        read_burst(8'h10, 6);
        write_burst(8'h13, 3);
        check_outputs();
        read_burst(8'h13, 2);
        test_end();

        test_begin("recovery after nack");
        wait_bus_idle();
        write_burst(8'h05, 2);
        check_outputs();
        read_burst(8'h04, 4);
        test_end();

        $display("tests passed: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
synth_i2c_pkg.sv
i2c_line_sync.sv
i2c_slave_engine.sv
synth_reg_bank.sv
synth_i2c_top.sv
tb_synth_i2c.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the I2C voice slave testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_synth_i2c \
    -f build.f -o tb_synth_i2c \
    && ./obj_dir/tb_synth_i2c | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
